/* compile.f */
+incdir+include
hdl/irda_mir_pkg.sv
hdl/irda_mir_data_ctrl.sv
hdl/irda_mir_flag_gen.sv
hdl/irda_mir_bit_stuffer.sv
hdl/irda_crc_ccitt16.sv
hdl/irda_mir_tx.sv
hdl/irda_mir_top.sv
verification/irda_mir_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f compile.f --top-module irda_mir_tb -o irda_mir_sim
out=$(./obj_dir/irda_mir_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

/* verification/irda_mir_tb.sv */
`timescale 1ns/1ps

module irda_mir_tb;
	import irda_mir_pkg::*;

	localparam int WAIT_CYC = 4000; // upper bound for every wait loop

	logic                   clk;
	logic                   wb_rst_i;
	logic                   tx_bit_en_i = 1'b0;
	logic [7:0]             tx_byte_i;
	logic                   tx_valid_i;
	logic                   tx_ready_o;
	logic                   count_mode_i;
	logic [FRAME_LEN_W-1:0] frame_len_i;
	logic                   underrun_end_i;
	logic                   clear_tx_i;
	logic                   sip_end_i;
	logic                   mir_tx_o;
	logic                   sip_o;

	int         errors;
	int         seed;
	logic [1:0] en_phase = 2'd0;  // strobe every fourth clock
	logic [7:0] raw_sr   = 8'hFF; // last 8 line bits
	int         ones     = 0;     // current run of ones on the line
	logic       in_frame = 1'b0;
	logic       bits_q[$];        // destuffed bits of the open frame
	logic [7:0] rx_frame[$];      // last decoded frame, fcs included
	logic [7:0] sent_q[$];        // bytes accepted by the DUT this frame
	int         frames_done = 0;
	int         frames_seen = 0;
	int         aborts      = 0;
	int         aborts_seen = 0;
	logic       ready_low_seen;

	irda_mir_top u_dut (
		.clk            (clk),
		.wb_rst_i       (wb_rst_i),
		.tx_bit_en_i    (tx_bit_en_i),
		.tx_byte_i      (tx_byte_i),
		.tx_valid_i     (tx_valid_i),
		.tx_ready_o     (tx_ready_o),
		.count_mode_i   (count_mode_i),
		.frame_len_i    (frame_len_i),
		.underrun_end_i (underrun_end_i),
		.clear_tx_i     (clear_tx_i),
		.sip_end_i      (sip_end_i),
		.mir_tx_o       (mir_tx_o),
		.sip_o          (sip_o)
	);

	always #5 clk = ~clk;

	////////////////////
	// hdlc stream decoder
	////////////////////
	task automatic decode_bit(input logic b);
		int i;
		int k;
		logic [7:0] byte_v;
		raw_sr = {b, raw_sr[7:1]};
		if (raw_sr == 8'h7E) begin // flag
			if (in_frame) begin
				for (i = 0; i < 7; i++)
					if (bits_q.size() > 0)
						void'(bits_q.pop_back()); // flag bits went in before it matched
				if (bits_q.size() > 0) begin // closing flag
					if (bits_q.size() % 8 != 0) begin
						$display("frame ended after %0d bits, not whole bytes", bits_q.size());
						errors++;
					end
					rx_frame.delete();
					for (k = 0; k < bits_q.size() / 8; k++) begin
						for (i = 0; i < 8; i++)
							byte_v[i] = bits_q[8*k+i]; // lsb first
						rx_frame.push_back(byte_v);
					end
					frames_done++;
					in_frame = 1'b0;
				end
			end else
				in_frame = 1'b1;
			bits_q.delete();
			ones = 0;
		end else if (b) begin
			ones++;
			if (ones == 7 && in_frame) begin // seven ones, frame abort
				aborts++;
				in_frame = 1'b0;
				bits_q.delete(); // aborted payload is dropped
			end
			if (in_frame)
				bits_q.push_back(1'b1);
		end else begin
			if (ones != 5 && in_frame)
				bits_q.push_back(1'b0); // a zero after five ones is stuffing
			ones = 0;
		end
	endtask

	// bit strobe and line sampling, mir_tx_o holds until the strobed edge
	always @(negedge clk) begin
		en_phase    = en_phase + 2'd1;
		tx_bit_en_i = (en_phase == 2'd3);
		if (tx_bit_en_i && !wb_rst_i)
			decode_bit(mir_tx_o);
	end

	// complemented reflected crc-ccitt over the accepted bytes
	function automatic logic [15:0] ref_crc();
		logic [15:0] crc;
		logic        fb;
		int          k;
		int          j;
		crc = 16'hFFFF;
		for (k = 0; k < sent_q.size(); k++)
			for (j = 0; j < 8; j++) begin
				fb  = crc[0] ^ sent_q[k][j];
				crc = crc >> 1;
				if (fb)
					crc = crc ^ 16'h8408;
			end
		return ~crc;
	endfunction

	////////////////////
	// host and check tasks
	////////////////////
	task automatic push_byte(input logic [7:0] b);
		int n;
		n          = 0;
		tx_byte_i  = b;
		tx_valid_i = 1'b1;
		while (!tx_ready_o && n < WAIT_CYC) begin
			ready_low_seen = 1'b1; // host held off
			@(negedge clk);
			n++;
		end
		if (!tx_ready_o) begin
			$display("tx_ready_o stayed low, byte %h was never accepted", b);
			errors++;
		end else
			sent_q.push_back(b);
		@(negedge clk); // handshake edge in between
	endtask

	task automatic push_random(input int cnt);
		int rnd;
		repeat (cnt) begin
			rnd = $random(seed);
			push_byte(rnd[7:0]);
		end
		tx_valid_i = 1'b0;
	endtask

	task automatic wait_frame(input string name);
		int          n;
		int          k;
		logic [15:0] exp_crc;
		logic [15:0] got_crc;
		n = 0;
		while (frames_done == frames_seen && n < WAIT_CYC) begin
			@(negedge clk);
			n++;
		end
		if (frames_done == frames_seen) begin
			$display("%s: no closing flag seen on the line", name);
			errors++;
		end else if (rx_frame.size() != sent_q.size() + 2) begin
			$display("FAILED %s: expected %0d bytes, actual %0d", name,
				sent_q.size() + 2, rx_frame.size());
			errors++;
		end else begin
			for (k = 0; k < sent_q.size(); k++)
				if (rx_frame[k] !== sent_q[k]) begin
					$display("FAILED %s: expected %h, actual %h", name, sent_q[k], rx_frame[k]);
					errors++;
				end
			exp_crc = ref_crc();
			got_crc = {rx_frame[sent_q.size()+1], rx_frame[sent_q.size()]}; // low byte first
			if (got_crc !== exp_crc) begin
				$display("FAILED %s: expected %h, actual %h", name, exp_crc, got_crc);
				errors++;
			end
		end
		if (aborts != aborts_seen) begin
			$display("%s: a run of seven ones broke the frame", name);
			errors++;
		end
		frames_seen = frames_done;
		aborts_seen = aborts;
	endtask

	task automatic wait_abort(input string name);
		int n;
		n = 0;
		while (aborts == aborts_seen && n < WAIT_CYC) begin
			@(negedge clk);
			n++;
		end
		if (aborts == aborts_seen) begin
			$display("%s: no break of ones seen on the line", name);
			errors++;
		end
		if (frames_done != frames_seen) begin
			$display("%s: frame was closed by a flag instead of a break", name);
			errors++;
		end
		frames_seen = frames_done;
		aborts_seen = aborts;
	endtask

	// sip request holds until sip_end_i, then the line idles high
	task automatic finish_sip(input string name);
		int   n;
		logic bad;
		n   = 0;
		bad = 1'b0;
		while (!sip_o && n < WAIT_CYC) begin
			@(negedge clk);
			n++;
		end
		if (!sip_o) begin
			$display("%s: sip_o never rose", name);
			errors++;
		end
		repeat (24) begin
			@(negedge clk);
			if (sip_o !== 1'b1)
				bad = 1'b1;
		end
		if (bad) begin
			$display("%s: sip_o fell before sip_end_i", name);
			errors++;
		end
		sip_end_i = 1'b1;
		@(negedge clk);
		sip_end_i = 1'b0;
		n = 0;
		while (sip_o && n < WAIT_CYC) begin
			@(negedge clk);
			n++;
		end
		if (sip_o) begin
			$display("%s: sip_o stayed high after sip_end_i", name);
			errors++;
		end
		bad = 1'b0;
		repeat (40) begin
			@(negedge clk);
			if (mir_tx_o !== 1'b1)
				bad = 1'b1;
		end
		if (bad) begin
			$display("%s: idle line was not constant one", name);
			errors++;
		end
	endtask

	initial begin
		int n;
		clk            = 1'b0;
		wb_rst_i       = 1'b1;
		tx_byte_i      = 8'h00;
		tx_valid_i     = 1'b0;
		count_mode_i   = 1'b0;
		frame_len_i    = '0;
		underrun_end_i = 1'b0;
		clear_tx_i     = 1'b0;
		sip_end_i      = 1'b0;
		errors         = 0;
		seed           = 3665;
		ready_low_seen = 1'b0;
		repeat (4) @(negedge clk);
		wb_rst_i = 1'b0;
		@(negedge clk);
		if (sip_o !== 1'b0 || tx_ready_o !== 1'b1) begin
			$display("FAILED reset: expected %b, actual %b", 2'b01, {sip_o, tx_ready_o});
			errors++;
		end

		// counted frame
		count_mode_i = 1'b1;
		frame_len_i  = 6;
		sent_q.delete();
		push_random(6);
		wait_frame("counted");
		finish_sip("counted");

		// open frame closed on underrun, bytes that force stuffing
		count_mode_i   = 1'b0;
		underrun_end_i = 1'b1;
		sent_q.delete();
		push_byte(8'hFF);
		push_byte(8'h7E);
		push_byte(8'hBF);
		push_byte(8'hFF);
		tx_valid_i = 1'b0;
		wait_frame("stuffing");
		finish_sip("stuffing");

		// open frame aborted on underrun
		underrun_end_i = 1'b0;
		sent_q.delete();
		push_random(3);
		wait_abort("underrun break");
		finish_sip("underrun break");

		// clear in mid payload, then a counted frame on a flushed buffer
		underrun_end_i = 1'b1;
		sent_q.delete();
		push_random(4);
		n = 0;
		while (bits_q.size() < 12 && n < WAIT_CYC) begin
			@(negedge clk);
			n++;
		end
		if (bits_q.size() < 12) begin
			$display("clear tx: payload never reached the line before the clear");
			errors++;
		end
		clear_tx_i = 1'b1;
		@(negedge clk);
		clear_tx_i = 1'b0;
		wait_abort("clear tx");
		finish_sip("clear tx");
		count_mode_i = 1'b1;
		frame_len_i  = 3;
		sent_q.delete();
		push_random(3);
		wait_frame("after clear");
		finish_sip("after clear");

		// host streams faster than the line
		frame_len_i    = 8;
		ready_low_seen = 1'b0;
		sent_q.delete();
		push_random(8);
		if (!ready_low_seen) begin
			$display("backpressure: tx_ready_o never dropped while bytes were waiting");
			errors++;
		end
		wait_frame("backpressure");
		finish_sip("backpressure");

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* hdl/irda_mir_top.sv */
`timescale 1ns/1ps

module irda_mir_top #(
	parameter int FRAME_LEN_W = irda_mir_pkg::FRAME_LEN_W
) (
	input  logic                   clk,
	input  logic                   wb_rst_i,
	input  logic                   tx_bit_en_i,    // mir bit rate strobe
	input  logic [7:0]             tx_byte_i,      // host byte stream
	input  logic                   tx_valid_i,
	output logic                   tx_ready_o,
	input  logic                   count_mode_i,
	input  logic [FRAME_LEN_W-1:0] frame_len_i,    // frame length in bytes
	input  logic                   underrun_end_i,
	input  logic                   clear_tx_i,
	input  logic                   sip_end_i,
	output logic                   mir_tx_o,
	output logic                   sip_o
);
	mir_data_if u_dif (); // bit path controller to sequencer

	irda_mir_data_ctrl u_data_ctrl (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.tx_byte_i  (tx_byte_i),
		.tx_valid_i (tx_valid_i),
		.tx_ready_o (tx_ready_o),
		.dif        (u_dif)
	);

	irda_mir_tx #(
		.FRAME_LEN_W (FRAME_LEN_W)
	) u_tx (
		.clk            (clk),
		.wb_rst_i       (wb_rst_i),
		.tx_bit_en_i    (tx_bit_en_i),
		.count_mode_i   (count_mode_i),
		.frame_len_i    (frame_len_i),
		.underrun_end_i (underrun_end_i),
		.clear_tx_i     (clear_tx_i),
		.sip_end_i      (sip_end_i),
		.dif            (u_dif),
		.mir_tx_o       (mir_tx_o),
		.sip_o          (sip_o)
	);

endmodule

/* hdl/irda_mir_tx.sv */
`timescale 1ns/1ps

module irda_mir_tx #(
	parameter int FRAME_LEN_W = irda_mir_pkg::FRAME_LEN_W
) (
	input  logic                   clk,
	input  logic                   wb_rst_i,
	input  logic                   tx_bit_en_i,    // one strobe per line bit
	input  logic                   count_mode_i,   // 1 counted, 0 open frame
	input  logic [FRAME_LEN_W-1:0] frame_len_i,    // bytes in counted mode
	input  logic                   underrun_end_i, // close instead of abort when dry
	input  logic                   clear_tx_i,
	input  logic                   sip_end_i,      // sip pulse done
	mir_data_if.seq                dif,
	output logic                   mir_tx_o,
	output logic                   sip_o           // sip pulse request
);
	import irda_mir_pkg::*;

	tx_state_e            state_q;
	tx_src_e              src_q;      // registered line select
	tx_src_e              src_eff;    // select after same-bit overrides
	logic [3:0]           cnt_q;      // flag, crc and break bits left
	logic [BIT_CNT_W-1:0] bit_cnt_q;  // payload bits sent
	logic [BIT_CNT_W-1:0] bit_cnt_nxt;
	logic [BIT_CNT_W-1:0] bit_limit;
	logic                 dc_restart_q;
	logic                 sip_seen_q;
	logic                 sip_done;
	logic                 flag_bit;
	logic                 stuff_in;
	logic                 stuff_out;
	logic                 take;
	logic                 crc_bit;
	logic                 stuffed_src;
	logic                 dry;
	logic                 close_on_dry;
	logic                 fg_restart;
	logic                 fg_shift;
	logic                 bs_restart;
	logic                 crc_en;
	logic                 crc_clear;
	logic                 crc_out;

	assign bit_cnt_nxt  = bit_cnt_q + 1'b1;
	assign bit_limit    = {(BIT_CNT_W-3)'(frame_len_i), 3'b000}; // bytes to bits
	assign dry          = (state_q == st_send_data) & take & ~dif.data_available;
	assign close_on_dry = ~count_mode_i & underrun_end_i;
	assign sip_done     = sip_end_i | sip_seen_q;

	// a dry buffer or a pending stuffed zero changes the source within the bit
	always_comb begin
		src_eff = src_q;
		if (dry)
			src_eff = close_on_dry ? src_stuffed_crc : src_brk_ones;
		else if (state_q == st_stop_frame && !take)
			src_eff = src_stuffed_crc; // stuffed zero after last fcs bit
	end

	assign stuffed_src = (src_eff == src_stuffed_data) | (src_eff == src_stuffed_crc);
	assign stuff_in    = (src_eff == src_stuffed_crc) ? crc_bit : dif.data_bit;
	assign fg_restart  = (state_q == st_idle);
	assign fg_shift    = (src_eff == src_flag);
	assign bs_restart  = (state_q == st_idle) | (state_q == st_sta_count);
	assign crc_en      = tx_bit_en_i & take & stuffed_src;
	assign crc_clear   = (state_q == st_sta_count);
	assign crc_out     = (src_eff == src_stuffed_crc);

	assign dif.next_data  = tx_bit_en_i & take & (src_eff == src_stuffed_data);
	assign dif.dc_restart = dc_restart_q;

	irda_mir_flag_gen u_flag_gen (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.bit_en_i   (tx_bit_en_i),
		.restart_i  (fg_restart),
		.shift_i    (fg_shift),
		.flag_bit_o (flag_bit)
	);

	irda_mir_bit_stuffer u_stuffer (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.bit_en_i    (tx_bit_en_i & stuffed_src),
		.restart_i   (bs_restart),
		.stuff_bit_i (stuff_in),
		.stuff_bit_o (stuff_out),
		.take_o      (take)
	);

	irda_crc_ccitt16 u_crc (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.bit_en_i  (crc_en),
		.clear_i   (crc_clear),
		.crc_out_i (crc_out),
		.crc_bit_i (dif.data_bit),
		.crc_bit_o (crc_bit)
	);

	////////////////////
	// frame sequencer
	////////////////////
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_q      <= st_idle;
			src_q        <= src_brk_ones;
			cnt_q        <= 4'd0;
			bit_cnt_q    <= '0;
			sip_o        <= 1'b0;
			dc_restart_q <= 1'b0;
			sip_seen_q   <= 1'b0;
		end else if (clear_tx_i) begin // abort at any edge
			state_q      <= st_brk;
			src_q        <= src_brk_ones;
			cnt_q        <= 4'd7;       // 8 ones
			sip_o        <= 1'b0;
			dc_restart_q <= 1'b1;
			sip_seen_q   <= 1'b0;
		end else begin
			dc_restart_q <= 1'b0;
			if (state_q == st_send_sip && sip_end_i)
				sip_seen_q <= 1'b1; // keep a short end pulse until the next strobe
			if (tx_bit_en_i) begin
				case (state_q)
				st_idle: begin
					if (dif.data_available) begin
						state_q   <= st_sta_count;
						src_q     <= src_flag;
						cnt_q     <= 4'd15; // two opening flags
						bit_cnt_q <= '0;
					end
				end
				st_sta_count: begin
					if (cnt_q == 4'd0) begin
						state_q <= st_send_data;
						src_q   <= src_stuffed_data;
					end else
						cnt_q <= cnt_q - 4'd1;
				end
				st_send_data: begin
					if (dry) begin
						if (close_on_dry) begin
							state_q <= st_crc_out;
							src_q   <= src_stuffed_crc;
							cnt_q   <= 4'd14; // first fcs bit already out
						end else begin
							state_q <= st_brk;
							src_q   <= src_brk_ones;
							cnt_q   <= 4'd6;  // this bit is the first one
						end
					end else if (take) begin
						bit_cnt_q <= bit_cnt_nxt;
						if (count_mode_i && (bit_cnt_nxt == bit_limit)) begin
							state_q <= st_crc_out;
							src_q   <= src_stuffed_crc;
							cnt_q   <= 4'd15;
						end
					end
				end
				st_crc_out: begin
					if (take) begin // stuffed zeros don't count
						if (cnt_q == 4'd0) begin
							state_q <= st_stop_frame;
							src_q   <= src_flag;
							cnt_q   <= 4'd7; // one closing flag
						end else
							cnt_q <= cnt_q - 4'd1;
					end
				end
				st_stop_frame: begin
					if (src_eff == src_flag) begin
						if (cnt_q == 4'd0) begin
							state_q <= st_send_sip;
							src_q   <= src_brk_ones;
							sip_o   <= 1'b1;
						end else
							cnt_q <= cnt_q - 4'd1;
					end
				end
				st_brk: begin
					if (cnt_q == 4'd0) begin
						state_q <= st_send_sip;
						sip_o   <= 1'b1;
					end else
						cnt_q <= cnt_q - 4'd1;
				end
				st_send_sip: begin
					if (sip_done) begin
						state_q    <= st_idle;
						sip_o      <= 1'b0;
						sip_seen_q <= 1'b0;
					end
				end
				default: state_q <= st_idle;
				endcase
			end
		end
	end

	// line output
	always_comb begin
		case (src_eff)
			src_brk_ones: mir_tx_o = 1'b1; // idle and break
			src_flag:     mir_tx_o = flag_bit;
			default:      mir_tx_o = stuff_out; // data and fcs both go through stuffer
		endcase
	end

endmodule

/* hdl/irda_crc_ccitt16.sv */
`timescale 1ns/1ps

module irda_crc_ccitt16 (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic bit_en_i,  // line strobe gated by stuffer take
	input  logic clear_i,   // reseed before a frame
	input  logic crc_out_i, // 0 accumulate, 1 shift out
	input  logic crc_bit_i, // payload bit
	output logic crc_bit_o  // fcs bit, lsb first
);
	import irda_mir_pkg::*;

	logic [15:0] crc_q;
	logic        fb;

	assign fb = crc_q[0] ^ crc_bit_i; // reflected feedback

	////////////////////
	// crc register
	////////////////////
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			crc_q <= CRC_SEED;
		else if (clear_i)
			crc_q <= CRC_SEED;
		else if (bit_en_i) begin
			if (crc_out_i)
				crc_q <= {1'b0, crc_q[15:1]}; // serial output
			else if (fb)
				crc_q <= {1'b0, crc_q[15:1]} ^ CRC_POLY;
			else
				crc_q <= {1'b0, crc_q[15:1]};
		end
	end

	// fcs is sent complemented
	assign crc_bit_o = ~crc_q[0];

endmodule

/* hdl/irda_mir_bit_stuffer.sv */
`timescale 1ns/1ps

module irda_mir_bit_stuffer (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic bit_en_i,    // strobe, only while a stuffed source is on the line
	input  logic restart_i,   // clear run count between frames
	input  logic stuff_bit_i,
	output logic stuff_bit_o,
	output logic take_o       // input bit consumed this bit time
);
	logic [2:0] ones_q; // run of ones already on the line
	logic       stuffing;

	assign stuffing    = (ones_q == 3'd5);
	assign take_o      = ~stuffing;                        // upstream stalls while zero goes out
	assign stuff_bit_o = stuffing ? 1'b0 : stuff_bit_i;

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			ones_q <= 3'd0;
		else if (restart_i)
			ones_q <= 3'd0;
		else if (bit_en_i) begin
			if (stuffing || !stuff_bit_i)
				ones_q <= 3'd0; // zero on line breaks the run
			else
				ones_q <= ones_q + 3'd1;
		end
	end

endmodule

/* hdl/irda_mir_flag_gen.sv */
`timescale 1ns/1ps

module irda_mir_flag_gen (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic bit_en_i,   // line bit strobe
	input  logic restart_i,  // back to first flag bit
	input  logic shift_i,    // flag bit goes out this bit time
	output logic flag_bit_o
);
	import irda_mir_pkg::*;

	logic [7:0] flag_q; // rotating flag copy

	// rotate right so bit 0 is always the next line bit,
	// after 8 shifts the pattern is back in phase
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			flag_q <= MIR_FLAG;
		else if (restart_i)
			flag_q <= MIR_FLAG;
		else if (bit_en_i && shift_i)
			flag_q <= {flag_q[0], flag_q[7:1]};
	end

	assign flag_bit_o = flag_q[0];

endmodule

/* hdl/irda_mir_data_ctrl.sv */
`timescale 1ns/1ps

// bit path between data controller and sequencer
interface mir_data_if;
	logic data_bit;       // current payload bit
	logic data_available; // a bit is held in the serializer
	logic next_data;      // consume pulse from sequencer
	logic dc_restart;     // flush buffer and serializer

	modport ctrl (output data_bit, output data_available, input next_data, input dc_restart);
	modport seq (input data_bit, input data_available, output next_data, output dc_restart);
endinterface

module irda_mir_data_ctrl (
	input  logic       clk,
	input  logic       wb_rst_i,
	input  logic [7:0] tx_byte_i,
	input  logic       tx_valid_i,
	output logic       tx_ready_o,
	mir_data_if.ctrl   dif
);
	logic [7:0] fifo_q [2]; // two byte slots
	logic       wr_ptr_q;
	logic       rd_ptr_q;
	logic [1:0] fill_q;     // 0..2 bytes waiting
	logic [7:0] shift_q;    // serializer, lsb goes first
	logic [2:0] pos_q;      // bit position inside the byte
	logic       shift_vld_q;
	logic       push;
	logic       last_bit;
	logic       load;

	assign tx_ready_o = (fill_q != 2'd2); // hold host off while both slots full
	assign push       = tx_valid_i & tx_ready_o;
	assign last_bit   = dif.next_data & (pos_q == 3'd7);
	assign load       = (fill_q != 2'd0) & (~shift_vld_q | last_bit); // refill serializer

	assign dif.data_bit       = shift_q[0];
	assign dif.data_available = shift_vld_q;

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wr_ptr_q    <= 1'b0;
			rd_ptr_q    <= 1'b0;
			fill_q      <= 2'd0;
			pos_q       <= 3'd0;
			shift_vld_q <= 1'b0;
		end else if (dif.dc_restart) begin // drop everything held
			wr_ptr_q    <= 1'b0;
			rd_ptr_q    <= 1'b0;
			fill_q      <= 2'd0;
			pos_q       <= 3'd0;
			shift_vld_q <= 1'b0;
		end else begin
			if (push)
				wr_ptr_q <= ~wr_ptr_q;
			if (load)
				rd_ptr_q <= ~rd_ptr_q;
			if (push && !load)
				fill_q <= fill_q + 2'd1;
			else if (load && !push)
				fill_q <= fill_q - 2'd1;
			if (load)
				pos_q <= 3'd0;
			else if (dif.next_data)
				pos_q <= pos_q + 3'd1; // wraps after bit 7
			if (load)
				shift_vld_q <= 1'b1;
			else if (last_bit)
				shift_vld_q <= 1'b0; // ran dry
		end
	end

	// byte storage
	always_ff @(posedge clk) begin
		if (push)
			fifo_q[wr_ptr_q] <= tx_byte_i;
		if (load)
			shift_q <= fifo_q[rd_ptr_q];
		else if (dif.next_data)
			shift_q <= {1'b0, shift_q[7:1]};
	end

endmodule

/* hdl/irda_mir_pkg.sv */
package irda_mir_pkg;

`include "irda_mir_defines.svh"

	localparam int FRAME_LEN_W = 16;              // byte count limit width
	localparam int BIT_CNT_W   = FRAME_LEN_W + 3; // counts bits, so 8x the byte limit

	localparam logic [7:0]  MIR_FLAG = `IRDA_MIR_FLAG;
	localparam logic [15:0] CRC_SEED = `IRDA_CRC_SEED;
	localparam logic [15:0] CRC_POLY = `IRDA_CRC_POLY;

	// frame sequencer states
	typedef enum logic [2:0] {
		st_idle,       // line idle, waiting for data
		st_sta_count,  // two opening flags
		st_send_data,  // stuffed payload
		st_crc_out,    // stuffed, complemented fcs
		st_stop_frame, // closing flag
		st_brk,        // abort with ones
		st_send_sip    // sip pulse request
	} tx_state_e;

	// line output source
	typedef enum logic [1:0] {
		src_brk_ones,
		src_flag,
		src_stuffed_data,
		src_stuffed_crc
	} tx_src_e;

endpackage

/* include/irda_mir_defines.svh */
`ifndef IRDA_MIR_DEFINES_SVH
`define IRDA_MIR_DEFINES_SVH

// hdlc style frame delimiter
`define IRDA_MIR_FLAG 8'h7E

// crc-ccitt start value
`define IRDA_CRC_SEED 16'hFFFF

// ccitt polynomial in reflected form for lsb first shifting
`define IRDA_CRC_POLY 16'h8408

`endif
